//--- src/gemm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared sizes and types for the 4x4 gemm accelerator
// covers the simplified axi channel structs, base address config
// and the accumulator matrix handed from the multiply engine to the dma
// ~~~~~~~~~~~~~~~~~~~~

package gemm_pkg;

    // array edge, matrices are sa_width x sa_width
    localparam int sa_width = 4;
    localparam int elem_w   = 32;
    localparam int acc_w    = 64;
    // one buffer word holds one row or column of four elements
    localparam int buf_dw   = sa_width * elem_w;
    localparam int buf_aw   = 2;

    // axi len field, 16 beats per matrix
    localparam logic [7:0] burst_len = 8'd15;
    // read ids, A and B bursts share the read port
    localparam logic id_a = 1'b0;
    localparam logic id_b = 1'b1;

    // base addresses of the three matrices
    typedef struct packed {
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] c_addr;
    } dma_cfg_t;

    // read address channel, request side
    typedef struct packed {
        logic        valid;
        logic        id;
        logic [31:0] addr;
        logic [7:0]  len;
    } ar_req_t;

    // read data channel
    typedef struct packed {
        logic        valid;
        logic        id;
        logic [31:0] data;
        logic        last;
    } r_rsp_t;

    // write address channel
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [7:0]  len;
    } aw_req_t;

    // write data channel, full words only
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } w_req_t;

    // [row][col] of 64-bit accumulators
    typedef logic signed [sa_width-1:0][sa_width-1:0][acc_w-1:0] acc_mat_t;

endpackage

//--- src/tile_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// tile buffer for one operand matrix
// dma side writes full words, mm side reads with one cycle latency
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tile_buffer (
    input  logic                          clk,
    input  logic                          wren_i,
    input  logic [gemm_pkg::buf_aw-1:0]   waddr_i,
    input  logic [gemm_pkg::buf_dw/8-1:0] wbe_i,
    input  logic [gemm_pkg::buf_dw-1:0]   wdata_i,
    input  logic [gemm_pkg::buf_aw-1:0]   raddr_i,
    output logic [gemm_pkg::buf_dw-1:0]   rdata_o
);
    import gemm_pkg::*;

    logic [buf_dw-1:0] mem [2**buf_aw];

    always_ff @(posedge clk) begin
        if (wren_i) begin
            // byte lanes
            for (int b = 0; b < buf_dw / 8; b++) begin
                if (wbe_i[b]) begin
                    mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        // registered read, old data on a same-address write
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- src/dma_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// dma control for one gemm run
// fetches A and B over the axi read port, packs beats into the buffers,
// kicks the multiply engine and writes C back as a single burst
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dma_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  gemm_pkg::dma_cfg_t            cfg_i,
    input  logic                          start_i,
    output logic                          done_o,
    output gemm_pkg::ar_req_t             ar_o,
    input  logic                          arready_i,
    input  gemm_pkg::r_rsp_t              r_i,
    output logic                          rready_o,
    output gemm_pkg::aw_req_t             aw_o,
    input  logic                          awready_i,
    output gemm_pkg::w_req_t              w_o,
    input  logic                          wready_i,
    input  logic                          bvalid_i,
    output logic                          bready_o,
    output logic                          buf_a_wren_o,
    output logic [gemm_pkg::buf_aw-1:0]   buf_a_waddr_o,
    output logic [gemm_pkg::buf_dw/8-1:0] buf_a_wbe_o,
    output logic [gemm_pkg::buf_dw-1:0]   buf_a_wdata_o,
    output logic                          buf_b_wren_o,
    output logic [gemm_pkg::buf_aw-1:0]   buf_b_waddr_o,
    output logic [gemm_pkg::buf_dw/8-1:0] buf_b_wbe_o,
    output logic [gemm_pkg::buf_dw-1:0]   buf_b_wdata_o,
    output logic                          mm_start_o,
    input  logic                          mm_done_i,
    input  gemm_pkg::acc_mat_t            accum_i
);
    import gemm_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_ADDR_A, ST_ADDR_B, ST_LOAD,
        ST_WAIT_MM, ST_ADDR_C, ST_WRITE_C, ST_WAIT_B
    } state_t;

    state_t     state;
    // beat position inside the current word, per id
    logic [1:0] beat_a;
    logic [1:0] beat_b;
    logic       full_a;
    logic       full_b;
    logic       full_a_nxt;
    logic       full_b_nxt;
    logic       hit_a;
    logic       hit_b;
    // write-back beat, row in [3:2], column in [1:0]
    logic [3:0] beat_c;

    // accepted read beats, routed by id
    assign hit_a = rready_o && r_i.valid && (r_i.id == id_a);
    assign hit_b = rready_o && r_i.valid && (r_i.id == id_b);

    // last word lands when the write address is all ones
    assign full_a_nxt = full_a || (buf_a_wren_o && (&buf_a_waddr_o));
    assign full_b_nxt = full_b || (buf_b_wren_o && (&buf_b_waddr_o));

    assign buf_a_wbe_o = '1;
    assign buf_b_wbe_o = '1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            beat_a        <= '0;
            beat_b        <= '0;
            beat_c        <= '0;
            full_a        <= 1'b0;
            full_b        <= 1'b0;
            buf_a_wren_o  <= 1'b0;
            buf_b_wren_o  <= 1'b0;
            buf_a_waddr_o <= '0;
            buf_b_waddr_o <= '0;
            mm_start_o    <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            // single-cycle strobes
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
            mm_start_o   <= 1'b0;
            done_o       <= 1'b0;

            // every fourth beat of an id completes a word
            if (hit_a) begin
                beat_a <= beat_a + 2'd1;
                if (&beat_a) begin
                    buf_a_wren_o <= 1'b1;
                end
            end
            if (hit_b) begin
                beat_b <= beat_b + 2'd1;
                if (&beat_b) begin
                    buf_b_wren_o <= 1'b1;
                end
            end
            // step to the next word after each write
            if (buf_a_wren_o) begin
                buf_a_waddr_o <= buf_a_waddr_o + 1'b1;
            end
            if (buf_b_wren_o) begin
                buf_b_waddr_o <= buf_b_waddr_o + 1'b1;
            end
            full_a <= full_a_nxt;
            full_b <= full_b_nxt;

            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state         <= ST_ADDR_A;
                        beat_a        <= '0;
                        beat_b        <= '0;
                        full_a        <= 1'b0;
                        full_b        <= 1'b0;
                        buf_a_waddr_o <= '0;
                        buf_b_waddr_o <= '0;
                    end
                end
                ST_ADDR_A: begin
                    if (arready_i) begin
                        state <= ST_ADDR_B;
                    end
                end
                ST_ADDR_B: begin
                    if (arready_i) begin
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    // both buffers complete, start the multiply next cycle
                    if (full_a_nxt && full_b_nxt) begin
                        mm_start_o <= 1'b1;
                        state      <= ST_WAIT_MM;
                    end
                end
                ST_WAIT_MM: begin
                    if (mm_done_i) begin
                        state <= ST_ADDR_C;
                    end
                end
                ST_ADDR_C: begin
                    if (awready_i) begin
                        state  <= ST_WRITE_C;
                        beat_c <= '0;
                    end
                end
                ST_WRITE_C: begin
                    // count only accepted beats
                    if (wready_i) begin
                        beat_c <= beat_c + 4'd1;
                        if (&beat_c) begin
                            state <= ST_WAIT_B;
                        end
                    end
                end
                ST_WAIT_B: begin
                    if (bvalid_i) begin
                        done_o <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // beat packing, earliest beat ends up in lane 3
    always_ff @(posedge clk) begin
        if (hit_a) begin
            buf_a_wdata_o <= {buf_a_wdata_o[buf_dw-elem_w-1:0], r_i.data};
        end
        if (hit_b) begin
            buf_b_wdata_o <= {buf_b_wdata_o[buf_dw-elem_w-1:0], r_i.data};
        end
    end

    // channel outputs follow the state, fields stay stable while waiting
    always_comb begin
        ar_o.valid = (state == ST_ADDR_A) || (state == ST_ADDR_B);
        ar_o.id    = (state == ST_ADDR_B) ? id_b : id_a;
        ar_o.addr  = (state == ST_ADDR_B) ? cfg_i.b_addr : cfg_i.a_addr;
        ar_o.len   = burst_len;
        // A beats may already come back while B's address waits
        rready_o   = (state == ST_ADDR_B) || (state == ST_LOAD);
        aw_o.valid = (state == ST_ADDR_C);
        aw_o.addr  = cfg_i.c_addr;
        aw_o.len   = burst_len;
        // low word of the accumulator, row-major order
        w_o.valid  = (state == ST_WRITE_C);
        w_o.data   = accum_i[beat_c[3:2]][beat_c[1:0]][elem_w-1:0];
        w_o.last   = &beat_c;
        bready_o   = (state == ST_WAIT_B);
    end

endmodule

//--- src/mm_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// output-stationary 4x4 multiply-accumulate array
// after a start pulse it streams buffer words 0..3 and sums the
// outer products of A columns and B rows, done pulses 6 cycles later
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mm_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    output logic                        done_o,
    output logic [gemm_pkg::buf_aw-1:0] buf_raddr_o,
    input  logic [gemm_pkg::buf_dw-1:0] buf_a_rdata_i,
    input  logic [gemm_pkg::buf_dw-1:0] buf_b_rdata_i,
    output gemm_pkg::acc_mat_t          accum_o
);
    import gemm_pkg::*;

    // read issue window, cycles 1..4 after start
    logic run;
    // read data present, cycles 2..5
    logic rd_vld;
    // marks the fourth read data cycle
    logic rd_last;
    // A lane per row, B lane per column
    logic signed [elem_w-1:0] a_row [sa_width];
    logic signed [elem_w-1:0] b_col [sa_width];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run         <= 1'b0;
            rd_vld      <= 1'b0;
            rd_last     <= 1'b0;
            done_o      <= 1'b0;
            buf_raddr_o <= '0;
        end else begin
            rd_vld  <= run;
            rd_last <= run && (&buf_raddr_o);
            // one cycle after the last accumulation
            done_o  <= rd_last;
            if (start_i) begin
                run         <= 1'b1;
                buf_raddr_o <= '0;
            end else if (run) begin
                buf_raddr_o <= buf_raddr_o + 1'b1;
                if (&buf_raddr_o) begin
                    run <= 1'b0;
                end
            end
        end
    end

    // lane 3 holds element 0
    always_comb begin
        for (int k = 0; k < sa_width; k++) begin
            a_row[k] = buf_a_rdata_i[(sa_width-1-k)*elem_w +: elem_w];
            b_col[k] = buf_b_rdata_i[(sa_width-1-k)*elem_w +: elem_w];
        end
    end

    // 16 cells, cleared on start, held after the run
    always_ff @(posedge clk) begin
        for (int i = 0; i < sa_width; i++) begin
            for (int j = 0; j < sa_width; j++) begin
                if (start_i) begin
                    accum_o[i][j] <= '0;
                end else if (rd_vld) begin
                    accum_o[i][j] <= $signed(accum_o[i][j]) + a_row[i] * b_col[j];
                end
            end
        end
    end

endmodule

//--- src/gemm_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// gemm accelerator top, dma engine plus two tile buffers and the mac array
// one simplified axi port faces external memory
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module gemm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  gemm_pkg::dma_cfg_t cfg_i,
    input  logic               start_i,
    output logic               done_o,
    output gemm_pkg::ar_req_t  ar_o,
    input  logic               arready_i,
    input  gemm_pkg::r_rsp_t   r_i,
    output logic               rready_o,
    output gemm_pkg::aw_req_t  aw_o,
    input  logic               awready_i,
    output gemm_pkg::w_req_t   w_o,
    input  logic               wready_i,
    input  logic               bvalid_i,
    output logic               bready_o
);
    import gemm_pkg::*;

    // buffer write side, driven by the dma
    logic                buf_a_wren;
    logic [buf_aw-1:0]   buf_a_waddr;
    logic [buf_dw/8-1:0] buf_a_wbe;
    logic [buf_dw-1:0]   buf_a_wdata;
    logic                buf_b_wren;
    logic [buf_aw-1:0]   buf_b_waddr;
    logic [buf_dw/8-1:0] buf_b_wbe;
    logic [buf_dw-1:0]   buf_b_wdata;
    // read side, shared address from the mac array
    logic [buf_aw-1:0]   buf_raddr;
    logic [buf_dw-1:0]   buf_a_rdata;
    logic [buf_dw-1:0]   buf_b_rdata;
    logic                mm_start;
    logic                mm_done;
    acc_mat_t            accum;

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_i         (cfg_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .ar_o          (ar_o),
        .arready_i     (arready_i),
        .r_i           (r_i),
        .rready_o      (rready_o),
        .aw_o          (aw_o),
        .awready_i     (awready_i),
        .w_o           (w_o),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wbe_o   (buf_a_wbe),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wbe_o   (buf_b_wbe),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    tile_buffer buf_a (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (buf_a_waddr),
        .wbe_i   (buf_a_wbe),
        .wdata_i (buf_a_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (buf_a_rdata)
    );

    tile_buffer buf_b (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (buf_b_waddr),
        .wbe_i   (buf_b_wbe),
        .wdata_i (buf_b_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .done_o        (mm_done),
        .buf_raddr_o   (buf_raddr),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_rdata_i (buf_b_rdata),
        .accum_o       (accum)
    );

endmodule

//--- sim/tb_gemm.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the gemm accelerator top
// axi memory model with random stalls and interleaved read beats,
// results compared against a reference multiply of the memory contents
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_gemm;
    import gemm_pkg::*;

    logic     clk = 1'b0;
    logic     rst_n;
    dma_cfg_t cfg;
    // base addresses for the next run, applied with the start pulse
    dma_cfg_t cfg_next;
    logic     start;
    logic     done;
    ar_req_t  ar;
    logic     arready;
    r_rsp_t   r;
    logic     rready;
    aw_req_t  aw;
    logic     awready;
    w_req_t   w;
    logic     wready;
    logic     bvalid;
    logic     bready;

    logic [31:0] lfsr = 32'h12b2_7d87;
    // external memory, 256 words, byte addresses wrap onto it
    logic [31:0] mem [256];
    logic [31:0] exp_c [16];
    int          stall;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    // read bursts in flight, indexed by id
    logic        rd_act [2];
    logic [31:0] rd_addr [2];
    int          rd_cnt [2];
    logic        r_fired;
    logic        r_sel;
    logic [31:0] wr_addr;
    logic        b_pend;
    logic [2:0]  b_delay;
    logic [31:0] w_prev;
    logic        w_stalled;
    // traffic seen during one run
    int          ar_count;
    logic        ar_id [2];
    logic [31:0] ar_addr [2];
    logic [7:0]  ar_len [2];
    int          aw_count;
    logic [31:0] aw_addr;
    logic [7:0]  aw_len;
    int          w_count;
    int          wlast_bad;
    int          w_early;
    int          w_unstable;
    logic        b_taken;
    int          done_count;
    int          done_early;
    int          r_count;
    int          r_switches;
    logic        r_last_id;

    gemm_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg),
        .start_i   (start),
        .done_o    (done),
        .ar_o      (ar),
        .arready_i (arready),
        .r_i       (r),
        .rready_o  (rready),
        .aw_o      (aw),
        .awready_i (awready),
        .w_o       (w),
        .wready_i  (wready),
        .bvalid_i  (bvalid),
        .bready_o  (bready)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        logic        fb;
        res = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            res  = {res[30:0], fb};
        end
        return res;
    endfunction

    function automatic int word_idx(input logic [31:0] base, input int beat);
        return int'(((base >> 2) + 32'(beat)) % 256);
    endfunction

    // word 4k+i of A is A[i][k], word 4k+j of B is B[k][j]
    function automatic logic [31:0] ref_elem(input int i, input int j);
        longint acc;
        longint av;
        longint bv;
        acc = 0;
        for (int k = 0; k < sa_width; k++) begin
            av  = $signed(mem[word_idx(cfg_next.a_addr, 4 * k + i)]);
            bv  = $signed(mem[word_idx(cfg_next.b_addr, 4 * k + j)]);
            acc = acc + av * bv;
        end
        // wraps mod 2^32
        return acc[31:0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_before);
        end
    endtask

    // all handshake outputs low
    task automatic check_quiet();
        check_word("done_o", 32'(done), 32'd0);
        check_word("ar_o.valid", 32'(ar.valid), 32'd0);
        check_word("aw_o.valid", 32'(aw.valid), 32'd0);
        check_word("w_o.valid", 32'(w.valid), 32'd0);
        check_word("rready_o", 32'(rready), 32'd0);
        check_word("bready_o", 32'(bready), 32'd0);
    endtask

    task automatic clear_model();
        rd_act[0]  = 1'b0;
        rd_act[1]  = 1'b0;
        rd_cnt[0]  = 0;
        rd_cnt[1]  = 0;
        r_fired    = 1'b0;
        b_pend     = 1'b0;
        w_stalled  = 1'b0;
        ar_count   = 0;
        aw_count   = 0;
        w_count    = 0;
        wlast_bad  = 0;
        w_early    = 0;
        w_unstable = 0;
        b_taken    = 1'b0;
        done_count = 0;
        done_early = 0;
        r_count    = 0;
        r_switches = 0;
    endtask

    // new matrices and three distinct 64-byte slots for A, B and C
    task automatic setup_run(input int stall_lvl);
        int sa;
        int sb;
        int sc;
        @(negedge clk);
        #1;
        sa = int'(rand_bits(4));
        sb = (sa + 1 + int'(rand_bits(2))) % 16;
        sc = (sa + 5 + int'(rand_bits(2))) % 16;
        cfg_next.a_addr = 32'h4000_0000 + 32'(sa * 64);
        cfg_next.b_addr = 32'h4000_0000 + 32'(sb * 64);
        cfg_next.c_addr = 32'h4000_0000 + 32'(sc * 64);
        for (int n = 0; n < 256; n++) begin
            mem[n] = rand_bits(32);
        end
        for (int n = 0; n < 16; n++) begin
            exp_c[n] = ref_elem(n / 4, n % 4);
        end
        stall = stall_lvl;
        clear_model();
    endtask

    task automatic run_gemm(input int stall_lvl);
        int cyc;
        setup_run(stall_lvl);
        @(posedge clk);
        #1;
        cfg   = cfg_next;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cyc = 0;
        while (!done && cyc < 3000) begin
            @(negedge clk);
            cyc++;
        end
        check_true(done, "timeout waiting for done_o");
        // window for a second done pulse
        repeat (3) @(negedge clk);
        #1;
    endtask

    task automatic check_result();
        for (int n = 0; n < 16; n++) begin
            check_word($sformatf("c[%0d][%0d]", n / 4, n % 4),
                       mem[word_idx(cfg.c_addr, n)], exp_c[n]);
        end
    endtask

    // handshakes sampled at the falling edge, inputs and outputs settled
    always @(negedge clk) begin
        r_fired = 1'b0;
        if (rst_n) begin
            if (ar.valid && arready) begin
                if (ar_count < 2) begin
                    ar_id[ar_count]   = ar.id;
                    ar_addr[ar_count] = ar.addr;
                    ar_len[ar_count]  = ar.len;
                end
                ar_count++;
                rd_act[ar.id]  = 1'b1;
                rd_addr[ar.id] = ar.addr;
                rd_cnt[ar.id]  = 0;
            end
            if (r.valid && rready) begin
                r_fired = 1'b1;
                // id changes between accepted beats
                if (r_count > 0 && r.id != r_last_id) begin
                    r_switches++;
                end
                r_last_id = r.id;
                r_count++;
                rd_cnt[r.id]++;
                if (rd_cnt[r.id] == 16) begin
                    rd_act[r.id] = 1'b0;
                end
            end
            if (aw.valid && awready) begin
                aw_count++;
                aw_addr = aw.addr;
                aw_len  = aw.len;
                wr_addr = aw.addr;
            end
            // a stalled beat must come back unchanged
            if (w_stalled && (!w.valid || w.data !== w_prev)) begin
                w_unstable++;
            end
            w_stalled = w.valid && !wready;
            w_prev    = w.data;
            if (w.valid && wready) begin
                if (aw_count == 0) begin
                    w_early++;
                end
                if (w.last != (w_count == 15)) begin
                    wlast_bad++;
                end
                mem[word_idx(wr_addr, w_count)] = w.data;
                w_count++;
                if (w_count == 16) begin
                    b_pend  = 1'b1;
                    b_delay = 3'(rand_bits(3));
                end
            end
            if (bvalid && bready) begin
                b_taken = 1'b1;
                b_pend  = 1'b0;
            end
            if (done) begin
                if (!b_taken) begin
                    done_early++;
                end
                done_count++;
            end
        end
    end

    // memory side, driven 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        arready = rand_bits(4) >= 32'(stall);
        awready = rand_bits(4) >= 32'(stall);
        wready  = rand_bits(4) >= 32'(stall);
        // an unaccepted beat holds, otherwise a new beat or a gap
        if (!r.valid || r_fired) begin
            r = '0;
            if ((rd_act[0] || rd_act[1]) && rand_bits(4) >= 32'(stall)) begin
                r_sel   = (rd_act[0] && rd_act[1]) ? (rand_bits(1) != 0) : rd_act[1];
                r.valid = 1'b1;
                r.id    = r_sel;
                r.data  = mem[word_idx(rd_addr[r_sel], rd_cnt[r_sel])];
                r.last  = (rd_cnt[r_sel] == 15);
            end
        end
        if (!b_pend) begin
            bvalid = 1'b0;
        end else if (!bvalid) begin
            if (b_delay == 0) begin
                bvalid = 1'b1;
            end else begin
                b_delay = b_delay - 3'd1;
            end
        end
    end

    initial begin
        int e;
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        cfg_next = '0;
        arready  = 1'b0;
        r        = '0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        stall    = 0;
        clear_model();

        e = errors;
        @(negedge clk);
        check_quiet();
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end
        report_test(1, "reset state", e);

        // one run with mild stalls covers tests 2 to 4
        e = errors;
        run_gemm(4);
        check_word("read requests", 32'(ar_count), 32'd2);
        check_word("ar_o.id of request 0", 32'(ar_id[0]), 32'd0);
        check_word("ar_o.addr of request 0", ar_addr[0], cfg.a_addr);
        check_word("ar_o.len of request 0", 32'(ar_len[0]), 32'd15);
        check_word("ar_o.id of request 1", 32'(ar_id[1]), 32'd1);
        check_word("ar_o.addr of request 1", ar_addr[1], cfg.b_addr);
        check_word("ar_o.len of request 1", 32'(ar_len[1]), 32'd15);
        report_test(2, "read requests", e);

        e = errors;
        check_word("write addresses", 32'(aw_count), 32'd1);
        check_word("aw_o.addr", aw_addr, cfg.c_addr);
        check_word("aw_o.len", 32'(aw_len), 32'd15);
        check_word("w beats", 32'(w_count), 32'd16);
        check_true(wlast_bad == 0, "wlast set on a beat other than the 16th");
        check_true(w_early == 0, "write data accepted before the write address");
        check_word("done_o pulses", 32'(done_count), 32'd1);
        check_true(done_early == 0, "done_o rose before the write response");
        report_test(3, "write-back framing", e);

        e = errors;
        check_result();
        report_test(4, "result", e);

        // heavy stalls on every channel
        e = errors;
        run_gemm(12);
        check_result();
        check_word("w beats", 32'(w_count), 32'd16);
        check_true(w_unstable == 0, "w_o changed while a beat was stalled");
        check_true(r_switches > 1, "read beats of A and B never interleaved");
        report_test(5, "back-pressure and interleave", e);

        e = errors;
        for (int run = 0; run < 3; run++) begin
            run_gemm(6);
            check_result();
            check_word("done_o pulses", 32'(done_count), 32'd1);
        end
        report_test(6, "repeated runs", e);

        $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
src/gemm_pkg.sv
src/tile_buffer.sv
src/dma_engine.sv
src/mm_engine.sv
src/gemm_top.sv
sim/tb_gemm.sv

//--- Makefile
# Verilator build and run for the gemm accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_gemm
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
